// File: list.f
+incdir+.
umi_mem_pkg.sv
umi_bank_router.sv
umi_memif.sv
umi_sram.sv
umi_resp_merge.sv
umi_mem_top.sv
tb_umi_mem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_umi_mem
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard *.sv *.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_umi_mem.sv
// random traffic stays within four words per bank; assumes 64-bit data, 32-bit address
`timescale 1ns/1ps
`include "umi_mem_macros.svh"

module tb_umi_mem;

   import umi_mem_pkg::*;

   localparam int NOPS        = 400;                      // random beats
   localparam int NB          = `UMI_DW/8;
   localparam int INIT_WORDS  = `UMI_NBANKS * 4;
   localparam int TIMEOUT     = 4 * (NOPS + INIT_WORDS) + 100;
   localparam int WSHIFT      = `UMI_OFFW + `UMI_BANKB;   // word index starts here
   localparam int MODEL_BYTES = 4 << WSHIFT;

   typedef struct {
      umi_resp_t resp;
      int        due;      // cycle count when seen at negedge
   } exp_t;

   logic                   clk;
   logic                   nreset;
   logic                   req_valid;
   logic                   req_ready;
   logic                   resp_valid;
   umi_req_t               req;
   umi_resp_t              resp;

   logic [31:0]            lfsr;
   logic [7:0]             model [MODEL_BYTES];  // byte image of the used words
   exp_t                   exp_q [$];
   int                     cyc;
   logic                   stall_vld;            // last edge took an atomic
   logic [`UMI_BANKW-1:0]  stall_bank;

   umi_mem_top i_umi_mem_top (
      .clk        (clk),
      .nreset     (nreset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp       (resp)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // cycle count, also the run limit
   initial begin
      cyc = 0;
      forever begin
         @(posedge clk);
         cyc++;
         if (cyc >= TIMEOUT) begin
            $display("run timed out after %0d cycles", cyc);
            end_in_failure();
         end
      end
   end

   // ######################################################################
   // helpers
   // ######################################################################

   task automatic end_in_failure;
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_resp(input umi_resp_t exp, input umi_resp_t act);
      if (act.rddata !== exp.rddata) begin
         $display("FAILED at %0t: resp.rddata expected %h got %h", $time, exp.rddata, act.rddata);
         end_in_failure();
      end else if (act.bank !== exp.bank) begin
         $display("FAILED at %0t: resp.bank expected %0d got %0d", $time, exp.bank, act.bank);
         end_in_failure();
      end
   endtask

   task automatic check_ready(input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAILED at %0t: req_ready expected %b got %b", $time, exp, act);
         end_in_failure();
      end
   endtask

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);        // one step per bit
         v    = {v[62:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [`UMI_BANKW-1:0] bank_of(input logic [`UMI_AW-1:0] a);
      return `UMI_BANKW'((a >> `UMI_OFFW) & (`UMI_NBANKS - 1));
   endfunction

   function automatic logic [`UMI_AW-1:0] make_addr(input int bank, input int word, input int off);
      return `UMI_AW'((word << WSHIFT) | (bank << `UMI_OFFW) | off);
   endfunction

   function automatic logic [`UMI_DW-1:0] model_word(input int base);
      logic [`UMI_DW-1:0] w;
      for (int i = 0; i < NB; i++) begin
         w[i*8 +: 8] = model[base + i];
      end
      return w;
   endfunction

   // sign extend a field of nb bytes
   function automatic logic signed [63:0] sext(input logic [63:0] v, input int nb);
      int sh;
      sh = 64 - 8 * nb;
      return $signed(v << sh) >>> sh;
   endfunction

   // new field value from old field and operand, both lsb aligned
   function automatic logic [63:0] atomic_result(input umi_atype_e t, input logic [63:0] old,
                                                 input logic [63:0] opnd, input int nb);
      logic [63:0] m;
      logic [63:0] a;
      logic [63:0] b;
      logic [63:0] res;
      m = (nb == 8) ? '1 : ((64'd1 << (8 * nb)) - 64'd1);
      a = old & m;
      b = opnd & m;
      case (t)
         UMI_ADD:  res = a + b;                   // truncated by m below
         UMI_AND:  res = a & b;
         UMI_OR:   res = a | b;
         UMI_XOR:  res = a ^ b;
         UMI_MAX:  res = (sext(b, nb) > sext(a, nb)) ? b : a;
         UMI_MIN:  res = (sext(b, nb) < sext(a, nb)) ? b : a;
         UMI_MAXU: res = (b > a) ? b : a;
         UMI_MINU: res = (b < a) ? b : a;
         default:  res = b;                       // swap, also unknown codes
      endcase
      return res & m;
   endfunction

   // ######################################################################
   // stimulus and model
   // ######################################################################

   // kind 0..2 read, 3..4 write, 5..6 atomic
   function automatic umi_req_t random_req(input int kind);
      umi_req_t r;
      int       size;
      int       off;
      int       maxt;
      r        = '0;
      r.read   = (kind < 3);
      r.write  = (kind == 3) || (kind == 4);
      r.atomic = (kind >= 5);
      size     = int'(rand_bits(2));
      off      = (int'(rand_bits(`UMI_OFFW)) >> size) << size;   // size aligned
      maxt     = (NB - off) >> size;                             // stays inside the word
      r.size   = 3'(size);
      r.len    = 8'(int'(rand_bits(3)) % maxt);
      r.addr   = make_addr(int'(rand_bits(`UMI_BANKB)), int'(rand_bits(2)), off);
      r.atype  = umi_atype_e'(8'(rand_bits(4)));
      r.wrdata = `UMI_DW'(rand_bits(64));
      return r;
   endfunction

   // model update at the accepting edge
   task automatic accept(input umi_req_t r);
      int                 off;
      int                 nb;
      int                 base;
      logic [`UMI_DW-1:0] old;
      logic [63:0]        res;
      exp_t               e;
      off  = int'(r.addr[`UMI_OFFW-1:0]);
      nb   = (int'(r.len) + 1) << r.size;
      base = int'(r.addr) - off;
      old  = model_word(base);
      if (r.read || r.atomic) begin
         e.resp.rddata = old >> (8 * off);        // atomics return the old word too
         e.resp.bank   = bank_of(r.addr);
         e.due         = cyc + 2;
         exp_q.push_back(e);
      end
      if (r.write || r.atomic) begin
         res = r.write ? r.wrdata : atomic_result(r.atype, old >> (8 * off), r.wrdata, nb);
         for (int i = 0; i < nb; i++) begin
            model[base + off + i] = res[8*i +: 8];
         end
      end
      stall_vld  = r.atomic;
      stall_bank = bank_of(r.addr);
   endtask

   // drive one beat, hold it until the target bank takes it
   task automatic send(input umi_req_t r);
      @(posedge clk);
      #1;
      req_valid = 1'b1;
      req       = r;
      @(negedge clk);
      check_ready(!(stall_vld && (stall_bank == bank_of(r.addr))), req_ready);
      while (!req_ready) begin
         stall_vld = 1'b0;                         // stall edge takes nothing
         @(negedge clk);
         check_ready(1'b1, req_ready);
      end
      accept(r);
   endtask

   task automatic idle_cycle;
      @(posedge clk);
      #1;
      req_valid = 1'b0;
      @(negedge clk);
      stall_vld = 1'b0;
   endtask

   // ######################################################################
   // response check
   // ######################################################################

   initial begin
      exp_t e;
      @(posedge nreset);
      forever begin
         @(negedge clk);
         if (resp_valid) begin
            if (exp_q.size() == 0) begin
               $display("response appeared with no read or atomic outstanding");
               end_in_failure();
            end else if (exp_q[0].due != cyc) begin
               $display("response came at cycle %0d, expected at %0d", cyc, exp_q[0].due);
               end_in_failure();
            end else begin
               e = exp_q.pop_front();
               check_resp(e.resp, resp);
            end
         end else if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
            $display("response due at cycle %0d did not arrive", cyc);
            end_in_failure();
         end
      end
   end

   // ######################################################################
   // main sequence
   // ######################################################################

   initial begin
      umi_req_t r;
      int       kind;
      lfsr       = 32'h9124;
      nreset     = 1'b0;
      req_valid  = 1'b0;
      req        = '0;
      stall_vld  = 1'b0;
      stall_bank = '0;
      repeat (10) @(posedge clk);
      #1;
      nreset = 1'b1;
      repeat (5) @(posedge clk);                   // quiet, any response here is an error

      // full word fill of every word the random phase touches
      for (int b = 0; b < `UMI_NBANKS; b++) begin
         for (int w = 0; w < 4; w++) begin
            r        = '0;
            r.write  = 1'b1;
            r.size   = 3'($clog2(NB));
            r.addr   = make_addr(b, w, 0);
            r.wrdata = `UMI_DW'({~r.addr, r.addr ^ 32'h6b3d_91e7});
            send(r);
         end
      end

      for (int n = 0; n < NOPS; n++) begin
         kind = int'(rand_bits(3));
         if (kind == 7) begin
            idle_cycle();                          // gap in the stream
         end else begin
            send(random_req(kind));
         end
      end
      idle_cycle();

      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      repeat (4) @(negedge clk);                   // no stray responses after drain
      $display("Testbench passed");
      $finish;
   end

endmodule

// File: umi_mem_top.sv
// resp_valid rises at edge N+1 for a beat taken at edge N and is seen high at edge N+2; no write acks
`timescale 1ns/1ps
`include "umi_mem_macros.svh"

module umi_mem_top (
   input  logic                      clk,
   input  logic                      nreset,
   // request
   input  logic                      req_valid,
   input  umi_mem_pkg::umi_req_t     req,
   output logic                      req_ready,
   // response, always accepted
   output logic                      resp_valid,
   output umi_mem_pkg::umi_resp_t    resp
);

   import umi_mem_pkg::*;

   logic [`UMI_NBANKS-1:0]  bank_valid;
   logic [`UMI_NBANKS-1:0]  bank_ready;
   umi_req_t                bank_req;                   // shared by all banks
   sram_req_t               sram_req    [`UMI_NBANKS];
   logic [`UMI_DW-1:0]      sram_rddata [`UMI_NBANKS];
   logic [`UMI_NBANKS-1:0]  rd_valid;
   logic [`UMI_DW-1:0]      rd_data     [`UMI_NBANKS];

   // ######################################################################
   // request decode
   // ######################################################################

   umi_bank_router u_router (
      .clk        (clk),
      .nreset     (nreset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .bank_valid (bank_valid),
      .bank_req   (bank_req),
      .bank_ready (bank_ready)
   );

   // ######################################################################
   // bank slices
   // ######################################################################

   for (genvar b = 0; b < `UMI_NBANKS; b++) begin : g_bank
      umi_memif u_memif (
         .clk         (clk),
         .nreset      (nreset),
         .valid       (bank_valid[b]),
         .req         (bank_req),
         .ready       (bank_ready[b]),
         .sram        (sram_req[b]),
         .sram_rddata (sram_rddata[b]),
         .rd_valid    (rd_valid[b]),
         .rd_data     (rd_data[b])
      );

      umi_sram u_sram (
         .clk    (clk),
         .nreset (nreset),
         .sram   (sram_req[b]),
         .rddata (sram_rddata[b])
      );
   end

   // results back to one port
   umi_resp_merge u_merge (
      .clk        (clk),
      .nreset     (nreset),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .resp_valid (resp_valid),
      .resp       (resp)
   );

endmodule

// File: umi_resp_merge.sv
// relies on equal result latency in every bank, so at most one bank reports per cycle
`timescale 1ns/1ps
`include "umi_mem_macros.svh"

module umi_resp_merge (
   input  logic                      clk,
   input  logic                      nreset,
   input  logic [`UMI_NBANKS-1:0]    rd_valid,
   input  logic [`UMI_DW-1:0]        rd_data [`UMI_NBANKS],
   output logic                      resp_valid,
   output umi_mem_pkg::umi_resp_t    resp
);

   import umi_mem_pkg::*;

   umi_resp_t resp_nxt;   // selected bank result

   // ######################################################################
   // select
   // ######################################################################

   always_comb begin
      resp_nxt = '0;
      for (int i = 0; i < `UMI_NBANKS; i++) begin
         if (rd_valid[i]) begin
            resp_nxt.rddata = rd_data[i];
            resp_nxt.bank   = `UMI_BANKW'(i);
         end
      end
   end

   // ######################################################################
   // output register
   // ######################################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= |rd_valid;   // single cycle pulse per result
      end
   end

   always_ff @(posedge clk) begin
      if (|rd_valid) begin
         resp <= resp_nxt;
      end
   end

   // fixed latency keeps bank results apart
   a_onehot_rd : assert property (
      @(posedge clk) disable iff (!nreset)
      $onehot0(rd_valid)
   ) else $error("merge: two banks returned in one cycle");

endmodule

// File: umi_sram.sv
// behavioural single port ram, read data registered, read returns the old word on a write
`timescale 1ns/1ps
`include "umi_mem_macros.svh"

module umi_sram (
   input  logic                      clk,
   input  logic                      nreset,
   input  umi_mem_pkg::sram_req_t    sram,
   output logic [`UMI_DW-1:0]        rddata
);

   localparam int NB = `UMI_DW/8;

   logic [`UMI_DW-1:0] mem [`UMI_BANK_WORDS];  // contents not cleared

   // ######################################################################
   // write, byte enabled
   // ######################################################################

   always_ff @(posedge clk) begin
      if (sram.ce && sram.we) begin
         for (int i = 0; i < NB; i++) begin
            if (sram.be[i]) begin
               mem[sram.idx][i*8 +: 8] <= sram.wrdata[i*8 +: 8];
            end
         end
      end
   end

   // ######################################################################
   // read, one cycle
   // ######################################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rddata <= '0;
      end else if (sram.ce) begin
         rddata <= mem[sram.idx];   // held while ce is low
      end
   end

endmodule

// File: umi_memif.sv
// no partial access may cross a word; atomics stall this bank one cycle and results see no back-pressure
`timescale 1ns/1ps
`include "umi_mem_macros.svh"

module umi_memif (
   input  logic                      clk,
   input  logic                      nreset,
   // request
   input  logic                      valid,
   input  umi_mem_pkg::umi_req_t     req,
   output logic                      ready,
   // sram
   output umi_mem_pkg::sram_req_t    sram,
   input  logic [`UMI_DW-1:0]        sram_rddata,
   // read / atomic result
   output logic                      rd_valid,
   output logic [`UMI_DW-1:0]        rd_data
);

   import umi_mem_pkg::*;

   localparam int NB  = `UMI_DW/8;           // bytes per word
   localparam int SHW = $clog2(`UMI_DW) + 1; // holds 0..DW

   logic                      acc;           // beat accepted
   logic [`UMI_OFFW-1:0]      off;
   logic [11:0]               lenp1;
   logic [11:0]               nbytes;
   logic [11:0]               end_byte;      // offset + bytes
   logic [11:0]               post_shift;    // DW - 8*end_byte
   logic [NB-1:0]             be;
   logic [`UMI_AW-1:0]        waddr;
   logic [`UMI_WIDXW-1:0]     idx;

   // atomic / read state
   logic                      atomic_r;      // write-back cycle with ready low
   logic [`UMI_OFFW-1:0]      off_r;
   logic [NB-1:0]             be_r;
   logic [`UMI_WIDXW-1:0]     idx_r;
   umi_atype_e                atype_r;
   logic [`UMI_DW-1:0]        op_r;          // operand left aligned
   logic [SHW-1:0]            shift_r;

   logic [`UMI_DW-1:0]        bitmask_r;
   logic [`UMI_DW-1:0]        old_al;        // old field left aligned
   logic [`UMI_DW-1:0]        merged;

   assign acc = valid & ready;

   // ######################################################################
   // byte count, mask, word index
   // ######################################################################

   assign off        = req.addr[`UMI_OFFW-1:0];
   assign lenp1      = {4'h0, req.len} + 12'd1;
   assign nbytes     = lenp1 << req.size;
   assign end_byte   = 12'(off) + nbytes;
   assign post_shift = 12'(`UMI_DW) - (end_byte << 3);

   always_comb begin
      for (int i = 0; i < NB; i++) begin
         be[i] = (12'(i) >= 12'(off)) && (12'(i) < end_byte);
      end
   end

   // skip offset and bank bits
   assign waddr = req.addr >> (`UMI_OFFW + `UMI_BANKB);
   assign idx   = waddr[`UMI_WIDXW-1:0];

   // ######################################################################
   // state
   // ######################################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         atomic_r <= 1'b0;
         rd_valid <= 1'b0;
      end else begin
         atomic_r <= acc & req.atomic;                 // one cycle only while ready drops
         rd_valid <= acc & (req.read | req.atomic);    // old value for atomics
      end
   end

   // payload captured on accept
   always_ff @(posedge clk) begin
      if (acc) begin
         off_r   <= off;
         be_r    <= be;
         idx_r   <= idx;
         atype_r <= req.atype;
         op_r    <= req.wrdata << (12'(`UMI_DW) - (nbytes << 3));  // field to the top
         shift_r <= post_shift[SHW-1:0];
      end
   end

   assign ready = ~atomic_r;

   // aligned down by the byte offset
   assign rd_data = sram_rddata >> (8 * off_r);

   // ######################################################################
   // atomic merge
   // ######################################################################

   always_comb begin
      for (int i = 0; i < NB; i++) begin
         bitmask_r[i*8 +: 8] = {8{be_r[i]}};
      end
   end

   // top aligned so signed compares see the field sign bit
   assign old_al = (sram_rddata & bitmask_r) << shift_r;

   always_comb begin
      case (atype_r)
         UMI_ADD:  merged = op_r + old_al;   // carry out of the field is lost
         UMI_AND:  merged = op_r & old_al;
         UMI_OR:   merged = op_r | old_al;
         UMI_XOR:  merged = op_r ^ old_al;
         UMI_MAX:  merged = ($signed(op_r) > $signed(old_al)) ? op_r : old_al;
         UMI_MIN:  merged = ($signed(op_r) > $signed(old_al)) ? old_al : op_r;
         UMI_MAXU: merged = (op_r > old_al) ? op_r : old_al;
         UMI_MINU: merged = (op_r > old_al) ? old_al : op_r;
         default:  merged = op_r;            // swap and unknown codes
      endcase
   end

   // ######################################################################
   // sram port
   // ######################################################################

   assign sram.ce     = acc | atomic_r;              // idle bank stays off
   assign sram.we     = (acc & req.write) | atomic_r;
   assign sram.idx    = atomic_r ? idx_r : idx;
   assign sram.be     = atomic_r ? be_r : be;
   assign sram.wrdata = atomic_r ? (merged >> shift_r)
                                 : (req.wrdata << (8 * off));

   // ######################################################################
   // checks
   // ######################################################################

   // write-back slot blocks the next beat and a swap lands the operand at the offset
   a_atomic_stall : assert property (
      @(posedge clk) disable iff (!nreset)
      (acc && req.atomic) |=> (!ready && sram.we &&
         (atype_r != UMI_SWAP ||
          ((sram.wrdata ^ ($past(req.wrdata) << (8 * off_r))) & bitmask_r) == '0))
   ) else $error("memif: no stall or wrong swap data after atomic");

   // access must fit inside one word
   a_fits_word : assert property (
      @(posedge clk) disable iff (!nreset)
      acc |-> (end_byte <= 12'(NB))
   ) else $error("memif: access crosses word boundary");

endmodule

// File: umi_bank_router.sv
// combinational decode; bank comes from the address bits right above the byte offset
`timescale 1ns/1ps
`include "umi_mem_macros.svh"

module umi_bank_router (
   input  logic                      clk,        // assertion only
   input  logic                      nreset,     // assertion only
   // requester side
   input  logic                      req_valid,
   input  umi_mem_pkg::umi_req_t     req,
   output logic                      req_ready,
   // bank side
   output logic [`UMI_NBANKS-1:0]    bank_valid,
   output umi_mem_pkg::umi_req_t     bank_req,
   input  logic [`UMI_NBANKS-1:0]    bank_ready
);

   logic [`UMI_AW-1:0]     word_addr;  // address in data words
   logic [`UMI_BANKW-1:0]  bank_sel;

   // ######################################################################
   // bank decode
   // ######################################################################

   assign word_addr = req.addr >> `UMI_OFFW;

   // mask keeps a single bank at index 0
   assign bank_sel = word_addr[`UMI_BANKW-1:0] & `UMI_BANKW'(`UMI_NBANKS - 1);

   // only the decoded bank sees valid
   always_comb begin
      bank_valid = '0;
      if (req_valid) begin
         bank_valid[bank_sel] = 1'b1;
      end
   end

   assign bank_req  = req;                   // broadcast, qualified by bank_valid
   assign req_ready = bank_ready[bank_sel];  // stall only from the target bank

   // ######################################################################
   // checks
   // ######################################################################

   // one command per beat
   a_one_cmd : assert property (
      @(posedge clk) disable iff (!nreset)
      req_valid |-> $onehot0({req.read, req.write, req.atomic})
   ) else $error("router: more than one of read/write/atomic set");

   // requester holds the beat while stalled
   a_hold_req : assert property (
      @(posedge clk) disable iff (!nreset)
      (req_valid && !req_ready) |=> (req_valid && $stable(req))
   ) else $error("router: request changed while stalled");

endmodule

// File: umi_mem_pkg.sv
// request, sram and response types; widths come from the macro header
`include "umi_mem_macros.svh"

package umi_mem_pkg;

   // ######################################################################
   // atomic opcodes, codes above 8 behave as swap
   // ######################################################################
   typedef enum logic [7:0] {
      UMI_ADD  = 8'h00,
      UMI_AND  = 8'h01,
      UMI_OR   = 8'h02,
      UMI_XOR  = 8'h03,
      UMI_MAX  = 8'h04,  // signed
      UMI_MIN  = 8'h05,  // signed
      UMI_MAXU = 8'h06,
      UMI_MINU = 8'h07,
      UMI_SWAP = 8'h08
   } umi_atype_e;

   // one request beat from the requester
   typedef struct packed {
      logic                 read;
      logic                 write;
      logic                 atomic;
      logic [2:0]           size;    // bytes per transfer = 1 << size
      logic [7:0]           len;     // transfers - 1
      umi_atype_e           atype;   // only looked at for atomics
      logic [`UMI_AW-1:0]   addr;
      logic [`UMI_DW-1:0]   wrdata;  // lsb aligned
   } umi_req_t;

   // single port sram access
   typedef struct packed {
      logic                   ce;
      logic                   we;
      logic [`UMI_WIDXW-1:0]  idx;     // word in bank
      logic [`UMI_DW/8-1:0]   be;      // byte write enables
      logic [`UMI_DW-1:0]     wrdata;
   } sram_req_t;

   // merged read / atomic result
   typedef struct packed {
      logic [`UMI_DW-1:0]     rddata;  // shifted down by byte offset
      logic [`UMI_BANKW-1:0]  bank;    // bank that produced it
   } umi_resp_t;

endpackage

// File: umi_mem_macros.svh
// bank count must be a power of two from 1 to 8; UMI_DW a power of two, at least 16 bits
`ifndef UMI_MEM_MACROS_SVH
`define UMI_MEM_MACROS_SVH

// ######################################################################
// datapath and address
// ######################################################################

`define UMI_DW 64                    // data word width in bits
`define UMI_AW 32                    // request address width

// byte offset within one data word
`define UMI_OFFW $clog2(`UMI_DW/8)

// ######################################################################
// banking
// ######################################################################

`define UMI_NBANKS 4                 // power of two, 1 to 8
`define UMI_BANK_WORDS 256           // depth of each bank

// address bits taken by the bank select, zero for a single bank
`define UMI_BANKB $clog2(`UMI_NBANKS)

// width of a bank index field, at least one bit
`define UMI_BANKW ((`UMI_NBANKS > 1) ? $clog2(`UMI_NBANKS) : 1)

// word index inside a bank
`define UMI_WIDXW $clog2(`UMI_BANK_WORDS)

`endif
